// File: build.f
+incdir+design
design/div_ctrl_pkg.sv
design/div_types_pkg.sv
design/div_operand_latch.sv
design/divider_control.sv
design/div_datapath.sv
design/divider_top.sv
verif/divider_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module divider_tb -Mdir obj_dir -f build.f; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vdivider_tb)
sim_status=$?
echo "$output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Verification passed" <<< "$output"; then
	exit 0
fi

exit 1

// File: verif/divider_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_macros.svh"

module divider_tb;

	localparam integer clk_period      = 100;
	localparam integer reset_cycles    = 16;
	localparam integer normal_latency  = 2 * `DIV_ITERATIONS + 3;  // shift, pairs, fix, output
	localparam integer special_latency = 3;
	localparam integer num_divisions   = 65;  // busy test counts twice for its quiet window
	localparam integer wait_limit      = 100;
	localparam integer watchdog_time   = (num_divisions * 80 + reset_cycles) * clk_period;
	localparam div_types_pkg::word_t most_neg = {1'b1, {(`DIV_WIDTH-1){1'b0}}};

	typedef struct packed {
		div_types_pkg::div_result_t pair;
		div_ctrl_pkg::div_status_t  status;
		div_types_pkg::word_t       selected;
	} expected_t;

	logic                       clk;
	logic                       reset;
	logic                       start;
	div_ctrl_pkg::div_op_e      op;
	div_types_pkg::word_t       dividend;
	div_types_pkg::word_t       divisor;
	logic                       ready;
	div_types_pkg::word_t       result;
	div_types_pkg::div_result_t result_detail;
	div_ctrl_pkg::div_status_t  status;
	logic                       result_valid;
	integer                     value_errors;
	integer                     protocol_errors;
	integer                     seed;

	divider_top u_dut (.*);

	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// reference model and checks
	//////////////////////////////////////////////////

	function automatic expected_t divide_reference(input div_ctrl_pkg::div_op_e f_op,
			input div_types_pkg::word_t a, input div_types_pkg::word_t b);
		expected_t e;
		logic      is_signed;
		is_signed = (f_op == div_ctrl_pkg::op_div) || (f_op == div_ctrl_pkg::op_rem);
		e = '0;
		if (b == '0) begin
			e.pair.quotient   = '1;
			e.pair.remainder  = a;
			e.status.div_zero = 1'b1;
		end else if (is_signed && (a == most_neg) && (b == '1)) begin
			e.pair.quotient        = a;
			e.pair.remainder       = '0;
			e.status.sign_overflow = 1'b1;
		end else if (is_signed) begin
			e.pair.quotient  = $signed(a) / $signed(b);  // truncates toward zero
			e.pair.remainder = $signed(a) % $signed(b);
		end else begin
			e.pair.quotient  = a / b;
			e.pair.remainder = a % b;
		end
		if ((f_op == div_ctrl_pkg::op_rem) || (f_op == div_ctrl_pkg::op_remu)) begin
			e.selected = e.pair.remainder;
		end else begin
			e.selected = e.pair.quotient;
		end
		return e;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			value_errors++;
			$display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic wait_for_ready();
		integer n;
		n = 0;
		while (!ready && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		assert (ready) else begin
			protocol_errors++;
			$display("t=%0t ready did not come back within %0d cycles", $time, wait_limit);
		end
	endtask

	// edge count from the negedge after the accepting edge, -1 on timeout
	task automatic wait_for_valid(output integer edges);
		integer n;
		n = 0;
		while (!result_valid && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		assert (result_valid) else begin
			protocol_errors++;
			$display("t=%0t result_valid did not arrive within %0d cycles", $time, wait_limit);
		end
		edges = result_valid ? n : -1;
	endtask

	task automatic issue_start(input div_ctrl_pkg::div_op_e t_op,
			input div_types_pkg::word_t a, input div_types_pkg::word_t b);
		wait_for_ready();
		op       = t_op;
		dividend = a;
		divisor  = b;
		start    = 1'b1;
		@(negedge clk);  // accepting edge has passed
		start    = 1'b0;
	endtask

	task automatic check_response(input string label, input expected_t expected,
			input integer latency, input integer edges);
		if (edges >= 0) begin
			assert (edges == latency) else begin
				protocol_errors++;
				$display("[ERROR] t=%0t %s latency: expected %0d, got %0d", $time, label,
					latency, edges);
			end
			check_value($sformatf("%s result", label), 64'(result), 64'(expected.selected));
			check_value($sformatf("%s result_detail", label), result_detail, expected.pair);
			check_value($sformatf("%s status", label), {62'd0, status}, {62'd0, expected.status});
			@(negedge clk);
			assert (!result_valid) else begin
				protocol_errors++;
				$display("t=%0t %s: result_valid stayed high past one cycle", $time, label);
			end
			check_value($sformatf("%s result hold", label), 64'(result), 64'(expected.selected));
		end
	endtask

	task automatic run_division(input string label, input div_ctrl_pkg::div_op_e t_op,
			input div_types_pkg::word_t a, input div_types_pkg::word_t b);
		expected_t expected;
		integer    latency;
		integer    edges;
		expected = divide_reference(t_op, a, b);
		latency  = (expected.status.div_zero || expected.status.sign_overflow) ?
			special_latency : normal_latency;
		issue_start(t_op, a, b);
		wait_for_valid(edges);
		check_response($sformatf("%s %s", t_op.name(), label), expected, latency, edges);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check_value("ready after reset", 64'(ready), 64'd1);
		check_value("result_valid after reset", 64'(result_valid), 64'd0);
	endtask

	task automatic test_unsigned();
		div_types_pkg::word_t a;
		div_types_pkg::word_t b;
		div_types_pkg::word_t shift;
		integer               i;
		run_division("100/7", div_ctrl_pkg::op_divu, 32'd100, 32'd7);
		run_division("100/7", div_ctrl_pkg::op_remu, 32'd100, 32'd7);
		run_division("max/1", div_ctrl_pkg::op_divu, 32'hffff_ffff, 32'd1);
		run_division("max/max", div_ctrl_pkg::op_remu, 32'hffff_ffff, 32'hffff_ffff);
		run_division("5/10", div_ctrl_pkg::op_divu, 32'd5, 32'd10);
		run_division("hex", div_ctrl_pkg::op_remu, 32'h1234_5678, 32'h0000_1000);
		for (i = 0; i < 40; i++) begin
			a     = $random(seed);
			b     = $random(seed);
			shift = $random(seed);
			b     = b >> shift[4:0];  // spread divisor sizes
			if (i[0]) begin
				run_division($sformatf("random %0d", i), div_ctrl_pkg::op_remu, a, b);
			end else begin
				run_division($sformatf("random %0d", i), div_ctrl_pkg::op_divu, a, b);
			end
		end
	endtask

	task automatic test_signed();
		run_division("7/2", div_ctrl_pkg::op_div, 32'sd7, 32'sd2);
		run_division("7/2", div_ctrl_pkg::op_rem, 32'sd7, 32'sd2);
		run_division("-7/2", div_ctrl_pkg::op_div, -32'sd7, 32'sd2);
		run_division("-7/2", div_ctrl_pkg::op_rem, -32'sd7, 32'sd2);
		run_division("7/-2", div_ctrl_pkg::op_div, 32'sd7, -32'sd2);
		run_division("7/-2", div_ctrl_pkg::op_rem, 32'sd7, -32'sd2);
		run_division("-7/-2", div_ctrl_pkg::op_div, -32'sd7, -32'sd2);
		run_division("-7/-2", div_ctrl_pkg::op_rem, -32'sd7, -32'sd2);
		run_division("-1000000/37", div_ctrl_pkg::op_div, -32'sd1000000, 32'sd37);
		run_division("min/1", div_ctrl_pkg::op_div, most_neg, 32'sd1);
	endtask

	task automatic test_div_zero();
		run_division("-5/0", div_ctrl_pkg::op_div, -32'sd5, 32'd0);
		run_division("123/0", div_ctrl_pkg::op_divu, 32'd123, 32'd0);
		run_division("min/0", div_ctrl_pkg::op_rem, most_neg, 32'd0);
		run_division("deadbeef/0", div_ctrl_pkg::op_remu, 32'hdead_beef, 32'd0);
	endtask

	task automatic test_overflow();
		run_division("min/-1", div_ctrl_pkg::op_div, most_neg, 32'hffff_ffff);
		run_division("min/-1", div_ctrl_pkg::op_rem, most_neg, 32'hffff_ffff);
		run_division("min/-1", div_ctrl_pkg::op_divu, most_neg, 32'hffff_ffff);  // plain divide
	endtask

	task automatic test_start_while_busy();
		expected_t expected;
		integer    edges;
		integer    extra;
		expected = divide_reference(div_ctrl_pkg::op_divu, 32'd1000, 32'd7);
		issue_start(div_ctrl_pkg::op_divu, 32'd1000, 32'd7);
		repeat (10) @(negedge clk);
		check_value("ready while busy", 64'(ready), 64'd0);
		op       = div_ctrl_pkg::op_remu;
		dividend = 32'd55;
		divisor  = 32'd9;
		start    = 1'b1;
		@(negedge clk);
		start    = 1'b0;
		wait_for_valid(edges);
		check_response("busy start", expected, normal_latency, (edges < 0) ? -1 : edges + 11);
		extra = 0;
		repeat (80) begin
			@(negedge clk);
			if (result_valid) extra++;
		end
		assert (extra == 0) else begin
			protocol_errors++;
			$display("t=%0t a start sent while busy produced %0d extra results", $time, extra);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		start           = 1'b0;
		op              = div_ctrl_pkg::op_divu;
		dividend        = '0;
		divisor         = '0;
		value_errors    = 0;
		protocol_errors = 0;
		seed            = 32'h061c_9b87;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_unsigned();
		test_signed();
		test_div_zero();
		test_overflow();
		test_start_while_busy();
		$display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("timeout: run still busy after %0d ns", watchdog_time);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/divider_top.sv
`timescale 1ns/10ps
`default_nettype none

module divider_top (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        start,
	input  div_ctrl_pkg::div_op_e      op,
	input  div_types_pkg::word_t       dividend,
	input  div_types_pkg::word_t       divisor,
	output logic                       ready,
	output div_types_pkg::word_t       result,
	output div_types_pkg::div_result_t result_detail,
	output div_ctrl_pkg::div_status_t  status,
	output logic                       result_valid
);

	div_types_pkg::div_operands_t operands;
	div_types_pkg::remainder_t    remainder;
	div_types_pkg::remainder_t    remainder_next;
	logic                         init;
	logic                         load_remainder;
	logic                         done;

	div_operand_latch u_latch (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.ready    (ready),
		.op       (op),
		.dividend (dividend),
		.divisor  (divisor),
		.operands (operands)
	);

	divider_control u_control (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.operands       (operands),
		.remainder      (remainder),
		.init           (init),
		.load_remainder (load_remainder),
		.remainder_next (remainder_next),
		.status         (status),
		.ready          (ready),
		.done           (done)
	);

	div_datapath u_datapath (
		.clk            (clk),
		.reset          (reset),
		.init           (init),
		.load_remainder (load_remainder),
		.done           (done),
		.operands       (operands),
		.remainder_next (remainder_next),
		.status         (status),
		.remainder      (remainder),
		.result         (result),
		.result_detail  (result_detail),
		.result_valid   (result_valid)
	);

endmodule

`default_nettype wire

// File: design/div_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_macros.svh"

module div_datapath (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          init,
	input  wire                          load_remainder,
	input  wire                          done,
	input  div_types_pkg::div_operands_t operands,
	input  div_types_pkg::remainder_t    remainder_next,
	input  div_ctrl_pkg::div_status_t    status,
	output div_types_pkg::remainder_t    remainder,
	output div_types_pkg::word_t         result,
	output div_types_pkg::div_result_t   result_detail,
	output logic                         result_valid
);

	div_types_pkg::remainder_t  rem_q;
	logic                       fin_q;       // done delayed by one edge
	logic                       quot_neg_q;
	logic                       rem_neg_q;
	logic                       sel_rem_q;
	div_types_pkg::div_result_t raw_pair;
	div_types_pkg::div_result_t fixed_pair;

	//////////////////////////////////////////////////
	// remainder register
	//////////////////////////////////////////////////

	assign remainder = init ? {{`DIV_WIDTH{1'b0}}, operands.dividend_mag} : rem_q;

	always_ff @(posedge clk) begin
		if (load_remainder) begin
			rem_q <= remainder_next;
		end
	end

	// sign and select info taken while the operands still belong to this division
	always_ff @(posedge clk) begin
		if (done) begin
			quot_neg_q <= operands.dividend_neg ^ operands.divisor_neg;
			rem_neg_q  <= operands.dividend_neg;
			sel_rem_q  <= (operands.op == div_ctrl_pkg::op_rem) ||
				(operands.op == div_ctrl_pkg::op_remu);
		end
	end

	//////////////////////////////////////////////////
	// sign correction and output
	//////////////////////////////////////////////////

	assign raw_pair.quotient  = rem_q[`DIV_WIDTH-1:0];
	assign raw_pair.remainder = rem_q[`DIV_REM_WIDTH-1 -: `DIV_WIDTH];

	always_comb begin
		fixed_pair = raw_pair;
		if (!(status.div_zero || status.sign_overflow)) begin
			if (quot_neg_q) begin
				fixed_pair.quotient = -raw_pair.quotient;
			end
			if (rem_neg_q) begin
				fixed_pair.remainder = -raw_pair.remainder;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fin_q) begin
			result_detail <= fixed_pair;
			result        <= sel_rem_q ? fixed_pair.remainder : fixed_pair.quotient;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fin_q        <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			fin_q        <= done;
			result_valid <= fin_q;  // one cycle pulse
		end
	end

endmodule

`default_nettype wire

// File: design/divider_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_macros.svh"

module divider_control (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          start,
	input  div_types_pkg::div_operands_t operands,
	input  div_types_pkg::remainder_t    remainder,
	output logic                         init,
	output logic                         load_remainder,
	output div_types_pkg::remainder_t    remainder_next,
	output div_ctrl_pkg::div_status_t    status,
	output logic                         ready,
	output logic                         done
);

	div_ctrl_pkg::div_state_e  state_q;
	div_ctrl_pkg::div_state_e  state_next;
	div_types_pkg::count_t     count_q;
	div_types_pkg::count_t     count_next;
	logic                      carry_q;     // bit shifted out of the upper half
	logic                      carry_next;
	logic                      borrow_q;    // last subtract went negative
	logic                      borrow_next;
	div_ctrl_pkg::div_status_t special;
	logic                      is_special;
	div_types_pkg::word_t      upper;
	div_types_pkg::word_t      lower;
	div_types_pkg::remainder_t shift_src;

	assign upper = remainder[`DIV_REM_WIDTH-1 -: `DIV_WIDTH];
	assign lower = remainder[`DIV_WIDTH-1:0];

	assign init = (state_q == div_ctrl_pkg::st_start);  // datapath presents {0, magnitude}

	//////////////////////////////////////////////////
	// special cases
	//////////////////////////////////////////////////

	assign special.div_zero      = (operands.divisor_mag == '0);
	assign special.sign_overflow = operands.dividend_neg && operands.divisor_neg &&
		(operands.divisor_mag == div_types_pkg::word_t'(1)) &&
		(operands.dividend_mag == {1'b1, {(`DIV_WIDTH-1){1'b0}}});
	assign is_special = special.div_zero | special.sign_overflow;

	// after a failed subtract the divisor is added back before shifting
	assign shift_src = borrow_q ? {upper + operands.divisor_mag, lower} : remainder;

	//////////////////////////////////////////////////
	// next state and remainder
	//////////////////////////////////////////////////

	always_comb begin
		load_remainder = 1'b0;
		remainder_next = remainder;
		ready          = 1'b0;
		done           = 1'b0;
		state_next     = state_q;
		count_next     = count_q;
		carry_next     = carry_q;
		borrow_next    = borrow_q;

		case (state_q)
			div_ctrl_pkg::st_load: begin
				ready = 1'b1;
				if (start) begin
					state_next = div_ctrl_pkg::st_start;
					count_next = div_types_pkg::count_t'(`DIV_ITERATIONS);
				end
			end
			div_ctrl_pkg::st_start: begin
				if (is_special) begin
					state_next = div_ctrl_pkg::st_finish;
				end else begin
					load_remainder = 1'b1;
					remainder_next = remainder << 1;
					carry_next     = remainder[`DIV_REM_WIDTH-1];
					state_next     = div_ctrl_pkg::st_subtract;
				end
			end
			div_ctrl_pkg::st_subtract: begin
				load_remainder = 1'b1;
				borrow_next    = ({carry_q, upper} < {1'b0, operands.divisor_mag});
				remainder_next = {upper - operands.divisor_mag, lower};  // exact when no borrow
				state_next     = div_ctrl_pkg::st_test;
			end
			div_ctrl_pkg::st_test: begin
				load_remainder = 1'b1;
				count_next     = count_q - div_types_pkg::count_t'(1);
				remainder_next = {shift_src[`DIV_REM_WIDTH-2:0], ~borrow_q};  // quotient bit
				carry_next     = shift_src[`DIV_REM_WIDTH-1];
				if (count_q == div_types_pkg::count_t'(1)) begin
					state_next = div_ctrl_pkg::st_finish;
				end else begin
					state_next = div_ctrl_pkg::st_subtract;
				end
			end
			div_ctrl_pkg::st_finish: begin
				ready          = 1'b1;
				done           = 1'b1;
				load_remainder = 1'b1;
				if (special.div_zero) begin
					remainder_next = {operands.dividend_raw, {`DIV_WIDTH{1'b1}}};
				end else if (special.sign_overflow) begin
					remainder_next = {{`DIV_WIDTH{1'b0}}, operands.dividend_raw};
				end else begin
					remainder_next = {carry_q, upper[`DIV_WIDTH-1:1], lower};  // undo last shift
				end
				if (start) begin
					state_next = div_ctrl_pkg::st_start;
					count_next = div_types_pkg::count_t'(`DIV_ITERATIONS);
				end else begin
					state_next = div_ctrl_pkg::st_load;
				end
			end
			default: begin
				state_next = div_ctrl_pkg::st_load;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q  <= div_ctrl_pkg::st_load;
			count_q  <= '0;
			carry_q  <= 1'b0;
			borrow_q <= 1'b0;
			status   <= '0;
		end else begin
			state_q  <= state_next;
			count_q  <= count_next;
			carry_q  <= carry_next;
			borrow_q <= borrow_next;
			if (done) begin
				status <= special;  // held with the result
			end
		end
	end

endmodule

`default_nettype wire

// File: design/div_operand_latch.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_macros.svh"

module div_operand_latch (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          start,
	input  wire                          ready,
	input  div_ctrl_pkg::div_op_e        op,
	input  div_types_pkg::word_t         dividend,
	input  div_types_pkg::word_t         divisor,
	output div_types_pkg::div_operands_t operands
);

	logic                 is_signed;
	logic                 dividend_neg;
	logic                 divisor_neg;
	div_types_pkg::word_t dividend_mag;
	div_types_pkg::word_t divisor_mag;

	//////////////////////////////////////////////////
	// sign handling
	//////////////////////////////////////////////////

	assign is_signed = (op == div_ctrl_pkg::op_div) || (op == div_ctrl_pkg::op_rem);

	assign dividend_neg = is_signed & dividend[`DIV_WIDTH-1];
	assign divisor_neg  = is_signed & divisor[`DIV_WIDTH-1];

	// two's complement magnitude, most negative value maps onto itself
	assign dividend_mag = dividend_neg ? -dividend : dividend;
	assign divisor_mag  = divisor_neg ? -divisor : divisor;

	//////////////////////////////////////////////////
	// capture on accepted start
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			operands <= '0;
		end else if (start && ready) begin
			operands.op           <= op;
			operands.dividend_raw <= dividend;
			operands.dividend_mag <= dividend_mag;
			operands.divisor_mag  <= divisor_mag;
			operands.dividend_neg <= dividend_neg;
			operands.divisor_neg  <= divisor_neg;
		end
	end

endmodule

`default_nettype wire

// File: design/div_types_pkg.sv
`default_nettype none

`include "div_macros.svh"

package div_types_pkg;

	typedef logic [`DIV_WIDTH-1:0]       word_t;
	typedef logic [`DIV_REM_WIDTH-1:0]   remainder_t;
	typedef logic [`DIV_COUNT_WIDTH-1:0] count_t;

	// latched request, magnitudes already formed
	typedef struct packed {
		div_ctrl_pkg::div_op_e op;
		word_t                 dividend_raw;
		word_t                 dividend_mag;
		word_t                 divisor_mag;
		logic                  dividend_neg;  // zero for unsigned ops
		logic                  divisor_neg;   // zero for unsigned ops
	} div_operands_t;

	typedef struct packed {
		word_t quotient;
		word_t remainder;
	} div_result_t;

endpackage

`default_nettype wire

// File: design/div_ctrl_pkg.sv
`default_nettype none

package div_ctrl_pkg;

	//////////////////////////////////////////////////
	// operation codes
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_div  = 2'd0,  // signed quotient
		op_divu = 2'd1,  // unsigned quotient
		op_rem  = 2'd2,  // signed remainder
		op_remu = 2'd3   // unsigned remainder
	} div_op_e;

	//////////////////////////////////////////////////
	// control FSM
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		st_load,
		st_start,
		st_subtract,
		st_test,
		st_finish
	} div_state_e;

	typedef struct packed {
		logic div_zero;
		logic sign_overflow;
	} div_status_t;

endpackage

`default_nettype wire

// File: design/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand and result width
`define DIV_WIDTH 32

// partial remainder in the upper half, dividend/quotient in the lower half
`define DIV_REM_WIDTH (2 * `DIV_WIDTH)

// one subtract/test pair per quotient bit
`define DIV_ITERATIONS 32

// wide enough to hold DIV_ITERATIONS
`define DIV_COUNT_WIDTH 7

`endif
